//--- include/tx_adapt_config.svh
// Widths and alignment thresholds for the AIB transmit adapter
// Include from any file that needs a width or threshold macro

`ifndef TX_ADAPT_CONFIG_SVH
`define TX_ADAPT_CONFIG_SVH

// One AIB transfer as seen on the channel
`define TX_XFER_W 40

// Two transfers paired into one word
`define TX_WORD_W 80

// Word with both marker bits stripped
`define TX_LANE_W 78

// Marker position inside each transfer
// 0 marks the lower half, 1 the upper half
`define TX_MARK_BIT 39

// Consecutive good pairs before lock
`define TX_LOCK_PAIRS 4

// Consecutive bad pairs before lock is dropped
`define TX_LOSS_PAIRS 2

// Width of the good and bad pair counters
`define TX_CNT_W 3

`endif

//--- source/tx_mode_pkg.sv
// Mode and state encodings for the transmit adapter
// Import where the map mode or the alignment state is needed

package tx_mode_pkg;

   // Static datapath map mode
   typedef enum logic [2:0] {
      MAP_OFF    = 3'd0,
      MAP_EHIP   = 3'd1,
      MAP_ELANE  = 3'd2,
      MAP_RSFEC  = 3'd3,
      MAP_PMADIR = 3'd4
   } tx_map_mode_e;

   // Word alignment state
   // Hunt until enough good pairs, locked until enough bad pairs
   typedef enum logic {
      ALIGN_HUNT   = 1'b0,
      ALIGN_LOCKED = 1'b1
   } tx_align_state_e;

endpackage : tx_mode_pkg

//--- source/tx_word_pkg.sv
// Data types for transfers, built words and unpacked lane data
// Import where any of the datapath types is used

`include "tx_adapt_config.svh"

package tx_word_pkg;

   // One 40-bit AIB transfer, marker at the top
   typedef logic [`TX_XFER_W-1:0] tx_xfer_t;

   // Built word, upper half above lower half
   typedef logic [`TX_WORD_W-1:0] tx_word_t;

   // Word without bits 79 and 39
   typedef logic [`TX_LANE_W-1:0] tx_lane_t;

endpackage : tx_word_pkg

//--- source/tx_word_if.sv
// Word and pair report bundle from the word builder
// Builder drives, counter reads pair reports, mapper reads the word

`timescale 1ns/1ps

interface tx_word_if
   import tx_word_pkg::*;
   ();

   // Built word, valid only while word_valid is high
   tx_word_t word;
   // One-cycle strobe, same cycle as pair_good
   logic     word_valid;
   // Pair reports, never high together
   logic     pair_good;
   logic     pair_bad;

   // Word builder side
   modport builder (
      output word,
      output word_valid,
      output pair_good,
      output pair_bad
   );

   // Alignment counter only needs the reports
   modport counter (
      input pair_good,
      input pair_bad
   );

   // Datapath mapper only needs the word
   modport mapper (
      input word,
      input word_valid
   );

endinterface : tx_word_if

//--- source/tx_word_builder.sv
// Pairs marked 40-bit AIB transfers into 80-bit words
// Reports every pairing attempt as good or bad, one cycle after the transfer

`timescale 1ns/1ps

`include "tx_adapt_config.svh"

module tx_word_builder
   import tx_word_pkg::*;
   (
   input  logic      tx_aib_transfer_clk,
   input  logic      tx_aib_transfer_rst_n,
   input  logic      xfer_valid,
   input  tx_xfer_t  xfer,
   tx_word_if.builder wif
);

   // Held lower half
   tx_xfer_t lower_q;
   // Set while a lower half waits for its upper half
   logic     lower_held;
   // Marker of the incoming transfer
   logic     mark;

   assign mark = xfer[`TX_MARK_BIT];

   // Pairing control and report strobes
   always_ff @(posedge tx_aib_transfer_clk or negedge tx_aib_transfer_rst_n) begin
      if (!tx_aib_transfer_rst_n) begin
         lower_held     <= 1'b0;
         wif.word_valid <= 1'b0;
         wif.pair_good  <= 1'b0;
         wif.pair_bad   <= 1'b0;
      end else begin
         // Strobes last one cycle
         wif.word_valid <= 1'b0;
         wif.pair_good  <= 1'b0;
         wif.pair_bad   <= 1'b0;
         if (xfer_valid) begin
            if (!mark) begin
               // New lower half, an older one is discarded as bad
               lower_held   <= 1'b1;
               wif.pair_bad <= lower_held;
            end else if (lower_held) begin
               // Upper half completes the pair
               lower_held     <= 1'b0;
               wif.word_valid <= 1'b1;
               wif.pair_good  <= 1'b1;
            end else begin
               // Upper half without a lower half
               wif.pair_bad <= 1'b1;
            end
         end
      end
   end

   // Payload registers
   always_ff @(posedge tx_aib_transfer_clk) begin
      if (xfer_valid && !mark) begin
         lower_q <= xfer;
      end
      // Word only captured on a completing upper half
      if (xfer_valid && mark && lower_held) begin
         wif.word <= {xfer, lower_q};
      end
   end

   // Good and bad reports are exclusive
   a_good_bad_excl : assert property (
      @(posedge tx_aib_transfer_clk) disable iff (!tx_aib_transfer_rst_n)
      !(wif.pair_good && wif.pair_bad)
   );

endmodule : tx_word_builder

//--- source/tx_align_counter.sv
// Counts runs of consecutive good and bad pairs for word alignment
// Feeds lock and loss thresholds to the alignment FSM

`timescale 1ns/1ps

`include "tx_adapt_config.svh"

module tx_align_counter (
   input  logic       tx_aib_transfer_clk,
   input  logic       tx_aib_transfer_rst_n,
   tx_word_if.counter wif,
   input  logic       cnt_clear,
   output logic       lock_reached,
   output logic       loss_reached
);

   // Saturation value for both counters
   localparam logic [`TX_CNT_W-1:0] CNT_MAX = '1;

   logic [`TX_CNT_W-1:0] good_cnt;
   logic [`TX_CNT_W-1:0] bad_cnt;

   // A good pair breaks a bad run and vice versa
   always_ff @(posedge tx_aib_transfer_clk or negedge tx_aib_transfer_rst_n) begin
      if (!tx_aib_transfer_rst_n) begin
         good_cnt <= '0;
         bad_cnt  <= '0;
      end else if (cnt_clear) begin
         // Fresh start on every state change
         good_cnt <= '0;
         bad_cnt  <= '0;
      end else if (wif.pair_good) begin
         if (good_cnt != CNT_MAX) begin
            good_cnt <= good_cnt + 1'b1;
         end
         bad_cnt <= '0;
      end else if (wif.pair_bad) begin
         if (bad_cnt != CNT_MAX) begin
            bad_cnt <= bad_cnt + 1'b1;
         end
         good_cnt <= '0;
      end
   end

   // Decoded from registered counts, seen the cycle after the strobe
   assign lock_reached = (good_cnt >= `TX_CNT_W'(`TX_LOCK_PAIRS));
   assign loss_reached = (bad_cnt >= `TX_CNT_W'(`TX_LOSS_PAIRS));

endmodule : tx_align_counter

//--- source/tx_align_fsm.sv
// Hunt/locked word alignment FSM
// Drives the registered word alignment command and clears the pair counters

`timescale 1ns/1ps

module tx_align_fsm
   import tx_mode_pkg::*;
   (
   input  logic tx_aib_transfer_clk,
   input  logic tx_aib_transfer_rst_n,
   input  logic lock_reached,
   input  logic loss_reached,
   output logic cnt_clear,
   output logic word_align_cmd
);

   tx_align_state_e state_q;
   tx_align_state_e state_d;

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ALIGN_HUNT: begin
            if (lock_reached) begin
               state_d = ALIGN_LOCKED;
            end
         end
         ALIGN_LOCKED: begin
            if (loss_reached) begin
               state_d = ALIGN_HUNT;
            end
         end
         default: begin
            state_d = ALIGN_HUNT;
         end
      endcase
   end

   // Counter restarts in the new state, same edge as the transition
   assign cnt_clear = (state_d != state_q);

   // State and command registers
   always_ff @(posedge tx_aib_transfer_clk or negedge tx_aib_transfer_rst_n) begin
      if (!tx_aib_transfer_rst_n) begin
         state_q        <= ALIGN_HUNT;
         word_align_cmd <= 1'b0;
      end else begin
         state_q        <= state_d;
         word_align_cmd <= (state_d == ALIGN_LOCKED);
      end
   end

   // Cleared counts must drop the threshold before the next cycle
   a_clear_single : assert property (
      @(posedge tx_aib_transfer_clk) disable iff (!tx_aib_transfer_rst_n)
      cnt_clear |=> !cnt_clear
   );

endmodule : tx_align_fsm

//--- source/tx_datapath_map.sv
// Maps locked words onto the EHIP, ELANE or RSFEC lane by static mode
// In PMA direct mode forwards raw transfers, marker optionally cleared

`timescale 1ns/1ps

`include "tx_adapt_config.svh"

module tx_datapath_map
   import tx_mode_pkg::*;
   import tx_word_pkg::*;
   (
   input  logic         tx_aib_transfer_clk,
   input  logic         tx_aib_transfer_rst_n,
   input  tx_map_mode_e map_mode,
   input  logic         wa_en,
   input  logic         word_align_cmd,
   tx_word_if.mapper    wif,
   input  logic         xfer_valid,
   input  tx_xfer_t     xfer,
   output tx_lane_t     tx_ehip_data,
   output tx_lane_t     tx_elane_data,
   output tx_lane_t     tx_rsfec_data,
   output logic         tx_ehip_valid,
   output logic         tx_elane_valid,
   output logic         tx_rsfec_valid,
   output tx_xfer_t     tx_pma_data,
   output logic         tx_pma_valid
);

   // Unpacked word, both markers dropped
   tx_lane_t lane_d;
   // Word may go out only while locked
   logic     lane_load;
   // PMA direct transfer
   tx_xfer_t pma_d;
   logic     pma_load;

   assign lane_d    = {wif.word[`TX_WORD_W-2:`TX_XFER_W], wif.word[`TX_MARK_BIT-1:0]};
   assign lane_load = wif.word_valid && word_align_cmd;
   assign pma_load  = xfer_valid && (map_mode == MAP_PMADIR);

   // Marker cleared when word alignment is enabled
   always_comb begin
      pma_d               = xfer;
      pma_d[`TX_MARK_BIT] = xfer[`TX_MARK_BIT] & ~wa_en;
   end

   // Lane and PMA registers, data holds until the next load
   always_ff @(posedge tx_aib_transfer_clk or negedge tx_aib_transfer_rst_n) begin
      if (!tx_aib_transfer_rst_n) begin
         tx_ehip_data   <= '0;
         tx_elane_data  <= '0;
         tx_rsfec_data  <= '0;
         tx_pma_data    <= '0;
         tx_ehip_valid  <= 1'b0;
         tx_elane_valid <= 1'b0;
         tx_rsfec_valid <= 1'b0;
         tx_pma_valid   <= 1'b0;
      end else begin
         // Valids are one-cycle strobes
         tx_ehip_valid  <= 1'b0;
         tx_elane_valid <= 1'b0;
         tx_rsfec_valid <= 1'b0;
         tx_pma_valid   <= pma_load;
         if (lane_load) begin
            case (map_mode)
               MAP_EHIP: begin
                  tx_ehip_data  <= lane_d;
                  tx_ehip_valid <= 1'b1;
               end
               MAP_ELANE: begin
                  tx_elane_data  <= lane_d;
                  tx_elane_valid <= 1'b1;
               end
               MAP_RSFEC: begin
                  tx_rsfec_data  <= lane_d;
                  tx_rsfec_valid <= 1'b1;
               end
               // OFF and PMA direct leave the lanes alone
               default: begin
               end
            endcase
         end
         if (pma_load) begin
            tx_pma_data <= pma_d;
         end
      end
   end

   // Only one destination per cycle
   a_valid_onehot : assert property (
      @(posedge tx_aib_transfer_clk) disable iff (!tx_aib_transfer_rst_n)
      $onehot0({tx_ehip_valid, tx_elane_valid, tx_rsfec_valid, tx_pma_valid})
   );

endmodule : tx_datapath_map

//--- source/tx_adapt_top.sv
// Transmit half of the AIB channel adapter
// Word builder, alignment counter and FSM, datapath mapper on one transfer clock

`timescale 1ns/1ps

module tx_adapt_top
   import tx_mode_pkg::*;
   import tx_word_pkg::*;
   (
   input  logic         tx_aib_transfer_clk,
   input  logic         tx_aib_transfer_rst_n,
   input  logic         xfer_valid,
   input  tx_xfer_t     xfer,
   input  tx_map_mode_e map_mode,
   input  logic         wa_en,
   output logic         word_align_cmd,
   output tx_lane_t     tx_ehip_data,
   output tx_lane_t     tx_elane_data,
   output tx_lane_t     tx_rsfec_data,
   output logic         tx_ehip_valid,
   output logic         tx_elane_valid,
   output logic         tx_rsfec_valid,
   output tx_xfer_t     tx_pma_data,
   output logic         tx_pma_valid
);

   // Counter and FSM handshake
   logic lock_reached;
   logic loss_reached;
   logic cnt_clear;

   // Built word and pair reports
   tx_word_if wif ();

   tx_word_builder u_builder (
      .tx_aib_transfer_clk   (tx_aib_transfer_clk),
      .tx_aib_transfer_rst_n (tx_aib_transfer_rst_n),
      .xfer_valid            (xfer_valid),
      .xfer                  (xfer),
      .wif                   (wif.builder)
   );

   tx_align_counter u_counter (
      .tx_aib_transfer_clk   (tx_aib_transfer_clk),
      .tx_aib_transfer_rst_n (tx_aib_transfer_rst_n),
      .wif                   (wif.counter),
      .cnt_clear             (cnt_clear),
      .lock_reached          (lock_reached),
      .loss_reached          (loss_reached)
   );

   tx_align_fsm u_fsm (
      .tx_aib_transfer_clk   (tx_aib_transfer_clk),
      .tx_aib_transfer_rst_n (tx_aib_transfer_rst_n),
      .lock_reached          (lock_reached),
      .loss_reached          (loss_reached),
      .cnt_clear             (cnt_clear),
      .word_align_cmd        (word_align_cmd)
   );

   tx_datapath_map u_map (
      .tx_aib_transfer_clk   (tx_aib_transfer_clk),
      .tx_aib_transfer_rst_n (tx_aib_transfer_rst_n),
      .map_mode              (map_mode),
      .wa_en                 (wa_en),
      .word_align_cmd        (word_align_cmd),
      .wif                   (wif.mapper),
      .xfer_valid            (xfer_valid),
      .xfer                  (xfer),
      .tx_ehip_data          (tx_ehip_data),
      .tx_elane_data         (tx_elane_data),
      .tx_rsfec_data         (tx_rsfec_data),
      .tx_ehip_valid         (tx_ehip_valid),
      .tx_elane_valid        (tx_elane_valid),
      .tx_rsfec_valid        (tx_rsfec_valid),
      .tx_pma_data           (tx_pma_data),
      .tx_pma_valid          (tx_pma_valid)
   );

endmodule : tx_adapt_top

//--- tests/tx_adapt_tb.sv
// Testbench for the AIB transmit adapter top level
// Random transfers from a fixed seed, checked every cycle against a cycle model

`timescale 1ns/1ps

`include "tx_adapt_config.svh"

module tx_adapt_tb
   import tx_mode_pkg::*;
   import tx_word_pkg::*;
   ();

   logic            clk;
   logic            rst_n;
   logic            xfer_valid;
   tx_xfer_t        xfer;
   tx_map_mode_e    map_mode;
   logic            wa_en;
   logic            word_align_cmd;
   tx_lane_t        tx_ehip_data;
   tx_lane_t        tx_elane_data;
   tx_lane_t        tx_rsfec_data;
   logic            tx_ehip_valid;
   logic            tx_elane_valid;
   logic            tx_rsfec_valid;
   tx_xfer_t        tx_pma_data;
   logic            tx_pma_valid;

   // Model state, updated on the rising edge
   logic            m_held;
   tx_xfer_t        m_lower;
   tx_word_t        m_word;
   logic            m_pg;
   logic            m_pb;
   int              m_good;
   int              m_bad;
   tx_align_state_e m_state;
   tx_align_state_e m_next;
   logic            m_cmd;
   tx_lane_t        m_ehip;
   tx_lane_t        m_elane;
   tx_lane_t        m_rsfec;
   logic            m_ehip_v;
   logic            m_elane_v;
   logic            m_rsfec_v;
   tx_xfer_t        m_pma;
   logic            m_pma_v;
   tx_xfer_t        pma_exp;

   string           cur_test;
   logic            next_mark;

   tx_adapt_top dut (
      .tx_aib_transfer_clk   (clk),
      .tx_aib_transfer_rst_n (rst_n),
      .xfer_valid            (xfer_valid),
      .xfer                  (xfer),
      .map_mode              (map_mode),
      .wa_en                 (wa_en),
      .word_align_cmd        (word_align_cmd),
      .tx_ehip_data          (tx_ehip_data),
      .tx_elane_data         (tx_elane_data),
      .tx_rsfec_data         (tx_rsfec_data),
      .tx_ehip_valid         (tx_ehip_valid),
      .tx_elane_valid        (tx_elane_valid),
      .tx_rsfec_valid        (tx_rsfec_valid),
      .tx_pma_data           (tx_pma_data),
      .tx_pma_valid          (tx_pma_valid)
   );

   always #2 clk = ~clk;

   // Word minus the two marker bits, low bits first
   function automatic tx_lane_t strip_markers(input tx_word_t w);
      tx_lane_t l;
      int       j;
      j = 0;
      for (int i = 0; i < `TX_WORD_W; i++) begin
         if (i != `TX_MARK_BIT && i != `TX_WORD_W - 1) begin
            l[j] = w[i];
            j++;
         end
      end
      return l;
   endfunction

   task automatic fail_run();
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_lane(input string what, input tx_lane_t exp, input tx_lane_t act);
      if (exp !== act) begin
         $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
         fail_run();
      end
   endtask

   task automatic check_pma(input string what, input tx_xfer_t exp, input tx_xfer_t act);
      if (exp !== act) begin
         $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
         fail_run();
      end
   endtask

   task automatic check_lock(input string what, input logic exp, input logic act);
      if (exp !== act) begin
         $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
         fail_run();
      end
   endtask

   // Cycle model of pairing, thresholds and lane routing
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_held    <= 1'b0;
         m_pg      <= 1'b0;
         m_pb      <= 1'b0;
         m_good    <= 0;
         m_bad     <= 0;
         m_state   <= ALIGN_HUNT;
         m_cmd     <= 1'b0;
         m_ehip    <= '0;
         m_elane   <= '0;
         m_rsfec   <= '0;
         m_ehip_v  <= 1'b0;
         m_elane_v <= 1'b0;
         m_rsfec_v <= 1'b0;
         m_pma     <= '0;
         m_pma_v   <= 1'b0;
      end else begin
         m_next = m_state;
         if (m_state == ALIGN_HUNT && m_good >= `TX_LOCK_PAIRS) m_next = ALIGN_LOCKED;
         if (m_state == ALIGN_LOCKED && m_bad >= `TX_LOSS_PAIRS) m_next = ALIGN_HUNT;
         m_state <= m_next;
         m_cmd   <= (m_next == ALIGN_LOCKED);
         // State change restarts both runs, a report on that edge is lost
         if (m_next != m_state) begin
            m_good <= 0;
            m_bad  <= 0;
         end else if (m_pg) begin
            m_good <= (m_good < 7) ? m_good + 1 : m_good;
            m_bad  <= 0;
         end else if (m_pb) begin
            m_bad  <= (m_bad < 7) ? m_bad + 1 : m_bad;
            m_good <= 0;
         end
         // Lanes only while locked in the word cycle
         m_ehip_v  <= m_pg && m_cmd && (map_mode == MAP_EHIP);
         m_elane_v <= m_pg && m_cmd && (map_mode == MAP_ELANE);
         m_rsfec_v <= m_pg && m_cmd && (map_mode == MAP_RSFEC);
         if (m_pg && m_cmd && map_mode == MAP_EHIP) m_ehip <= strip_markers(m_word);
         if (m_pg && m_cmd && map_mode == MAP_ELANE) m_elane <= strip_markers(m_word);
         if (m_pg && m_cmd && map_mode == MAP_RSFEC) m_rsfec <= strip_markers(m_word);
         // PMA direct ignores lock
         pma_exp = xfer;
         if (wa_en) pma_exp[`TX_MARK_BIT] = 1'b0;
         m_pma_v <= xfer_valid && (map_mode == MAP_PMADIR);
         if (xfer_valid && map_mode == MAP_PMADIR) m_pma <= pma_exp;
         // Pairing rule
         m_pg <= xfer_valid && xfer[`TX_MARK_BIT] && m_held;
         m_pb <= xfer_valid && (xfer[`TX_MARK_BIT] ? !m_held : m_held);
         if (xfer_valid && !xfer[`TX_MARK_BIT]) begin
            m_held  <= 1'b1;
            m_lower <= xfer;
         end else if (xfer_valid && m_held) begin
            m_held <= 1'b0;
            m_word <= {xfer, m_lower};
         end
      end
   end

   // Outputs are registered, so compare on the falling edge
   always @(negedge clk) begin
      check_lock("word_align_cmd", m_cmd, word_align_cmd);
      check_lock("tx_ehip_valid", m_ehip_v, tx_ehip_valid);
      check_lock("tx_elane_valid", m_elane_v, tx_elane_valid);
      check_lock("tx_rsfec_valid", m_rsfec_v, tx_rsfec_valid);
      check_lock("tx_pma_valid", m_pma_v, tx_pma_valid);
      check_lane("tx_ehip_data", m_ehip, tx_ehip_data);
      check_lane("tx_elane_data", m_elane, tx_elane_data);
      check_lane("tx_rsfec_data", m_rsfec, tx_rsfec_data);
      check_pma("tx_pma_data", m_pma, tx_pma_data);
   end

   // One cycle of stimulus, a gap in about one cycle of four
   task automatic drive_xfer(input int corrupt_pct);
      logic mark;
      @(negedge clk);
      xfer = {8'($urandom), $urandom};
      xfer_valid = ($urandom_range(3) != 0);
      if (xfer_valid) begin
         if ($urandom_range(99) < corrupt_pct) mark = 1'($urandom_range(1));
         else mark = next_mark;
         xfer[`TX_MARK_BIT] = mark;
         next_mark = ~mark;
      end
   endtask

   task automatic drive_many(input int n, input int corrupt_pct);
      repeat (n) drive_xfer(corrupt_pct);
   endtask

   // Keeps driving until the lock command settles, bounded
   task automatic drive_until_lock(input logic exp, input int corrupt_pct, input int limit);
      int cnt;
      cnt = 0;
      while (word_align_cmd !== exp && cnt < limit) begin
         drive_xfer(corrupt_pct);
         cnt++;
      end
      if (word_align_cmd !== exp) begin
         $display("timeout in %s: word_align_cmd did not become %b within %0d cycles",
                  cur_test, exp, limit);
         fail_run();
      end
   endtask

   task automatic set_mode(input string name, input tx_map_mode_e mode, input logic wa);
      cur_test = name;
      map_mode = mode;
      wa_en    = wa;
   endtask

   initial begin
      void'($urandom(32'h9e2));
      clk        = 1'b0;
      rst_n      = 1'b0;
      xfer_valid = 1'b0;
      xfer       = '0;
      map_mode   = MAP_OFF;
      wa_en      = 1'b0;
      next_mark  = 1'b0;
      cur_test   = "reset";
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      set_mode("lock_ehip", MAP_EHIP, 1'b1);
      drive_until_lock(1'b1, 0, 100);
      drive_many(30, 0);
      set_mode("lane_elane", MAP_ELANE, 1'b0);
      drive_many(30, 0);
      set_mode("lane_rsfec", MAP_RSFEC, 1'b1);
      drive_many(30, 0);
      set_mode("lane_off", MAP_OFF, 1'b1);
      drive_many(20, 0);
      // Random markers break pairing until lock drops
      set_mode("loss", MAP_EHIP, 1'b1);
      drive_until_lock(1'b0, 100, 100);
      drive_many(20, 100);
      set_mode("regain", MAP_RSFEC, 1'b0);
      drive_until_lock(1'b1, 0, 100);
      drive_many(20, 0);
      set_mode("noisy", MAP_ELANE, 1'b1);
      drive_many(80, 20);
      set_mode("pma_wa", MAP_PMADIR, 1'b1);
      drive_many(30, 30);
      set_mode("pma_raw", MAP_PMADIR, 1'b0);
      drive_many(30, 30);
      set_mode("back_ehip", MAP_EHIP, 1'b1);
      drive_many(40, 5);
      // Drain the pipeline under the checker
      @(negedge clk);
      xfer_valid = 1'b0;
      repeat (4) @(negedge clk);
      $display("Finished with no errors");
      $finish;
   end

endmodule : tx_adapt_tb

//--- all.f
+incdir+include
source/tx_mode_pkg.sv
source/tx_word_pkg.sv
source/tx_word_if.sv
source/tx_word_builder.sv
source/tx_align_counter.sv
source/tx_align_fsm.sv
source/tx_datapath_map.sv
source/tx_adapt_top.sv
tests/tx_adapt_tb.sv

//--- Bender.yml
package:
  name: tx_adapt

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/tx_mode_pkg.sv
      - source/tx_word_pkg.sv
      - source/tx_word_if.sv
      - source/tx_word_builder.sv
      - source/tx_align_counter.sv
      - source/tx_align_fsm.sv
      - source/tx_datapath_map.sv
      - source/tx_adapt_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tx_adapt_tb.sv
